// File: Bender.yml
package:
  name: audio_mixer

sources:
  - src/audio_pkg.sv
  - src/audio_pdm_dac.sv
  - src/audio_fetch.sv
  - src/audio_channel.sv
  - src/audio_mix.sv
  - src/audio_mixer.sv
  - target: simulation
    files:
      - sim/audio_mixer_assertions.sv
      - sim/audio_mixer_tb.sv

// File: audio_mixer.f
src/audio_pkg.sv
src/audio_pdm_dac.sv
src/audio_fetch.sv
src/audio_channel.sv
src/audio_mix.sv
src/audio_mixer.sv
sim/audio_mixer_assertions.sv
sim/audio_mixer_tb.sv

// File: sim/audio_mixer_assertions.sv
/* Memory port and reload pulse properties, bound into audio_mixer.
   The idle rule allows a pending request up to 12 cycles to drain. */

module audio_mixer_assertions
    import audio_pkg::*;
(
    input logic                   clk,
    input logic                   reset_i,
    input logic                   enable_i,
    input logic [AUDIO_NCHAN-1:0] reload_o,
    input mem_req_t               mem_req_o,
    input logic                   ack_i
);

    int         fail_cnt = 0;           // read by the testbench at the end
    logic [3:0] idle_cnt;               // cycles with enable low, saturating

    always_ff @(posedge clk) begin
        if (reset_i || enable_i) begin
            idle_cnt <= '0;
        end else if (idle_cnt != 4'hf) begin
            idle_cnt <= idle_cnt + 1'b1;
        end
    end

    req_hold: assert property (@(posedge clk) disable iff (reset_i)
        mem_req_o.req && !ack_i |=> mem_req_o.req && $stable(mem_req_o.addr))
        else begin
            $error("request dropped or address moved before ack");
            fail_cnt++;
        end

    reload_single: assert property (@(posedge clk) disable iff (reset_i)
        |reload_o |=> (reload_o & $past(reload_o)) == '0)
        else begin
            $error("reload pulse longer than one cycle");
            fail_cnt++;
        end

    idle_no_req: assert property (@(posedge clk) disable iff (reset_i)
        idle_cnt >= 4'd12 |-> !mem_req_o.req)
        else begin
            $error("memory request while disabled");
            fail_cnt++;
        end

endmodule

// File: sim/audio_mixer_stim.txt
// per test: enable fill_word exp_pdm_l_ones exp_pdm_r_ones
// then per channel 0..3: vol_l vol_r period start len
1 1010 8E 90
20 10 14 0000 3  10 10 18 0100 2  08 10 1C 0200 3  00 10 20 0300 1
1 4040 FF 80
7F 00 14 0000 3  7F 00 18 0100 2  7F 00 1C 0200 3  7F 00 20 0300 1
1 C0C0 00 60
7F 08 14 0000 3  7F 08 18 0100 2  7F 08 1C 0200 3  7F 08 20 0300 1
0 1010 80 80
20 10 14 0000 3  10 10 18 0100 2  08 10 1C 0200 3  00 10 20 0300 1

// File: sim/audio_mixer_tb.sv
/* Testbench for audio_mixer; stimulus from sim/audio_mixer_stim.txt.
   Channel starts must sit at channel*0x100 so requests map back to channels. */

module audio_mixer_tb
    import audio_pkg::*;
();

    localparam int NTESTS  = 4;
    localparam int FIELDS  = 24;        // words per test in the stim file
    localparam int TIMEOUT = 3000;      // cycles per wait

    logic clk, reset_i, enable_i, ack_i, pdm_l, pdm_r;
    chan_cfg_t cfg [AUDIO_NCHAN];
    logic [AUDIO_NCHAN-1:0] restart_i, reload_o;
    mem_req_t mem_req;
    word_t word_i, fill_word;
    logic [31:0] stim [0:NTESTS*FIELDS-1];
    logic [15:0] lfsr;
    int reload_cnt [AUDIO_NCHAN];
    int ack_cnt [AUDIO_NCHAN];
    addr_t exp_addr [AUDIO_NCHAN];
    int errors, checks;
    bit timed_out;

    audio_mixer UUT (
        .clk(clk), .reset_i(reset_i), .enable_i(enable_i), .cfg_i(cfg),
        .restart_i(restart_i), .reload_o(reload_o), .mem_req_o(mem_req),
        .ack_i(ack_i), .word_i(word_i), .pdm_l_o(pdm_l), .pdm_r_o(pdm_r)
    );

    bind audio_mixer audio_mixer_assertions u_assert (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // galois lfsr, taps 16,14,13,11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] field(input int t, input int k);
        return stim[t*FIELDS + k];
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %0t %s expected %0d got %0d", $time, name, expected, actual);
        end
    endtask

    // memory model plus request and reload monitor
    initial begin : memory_model
        int  wait_left;
        int  c;
        bit  armed;
        armed     = 1'b0;
        wait_left = 0;
        forever begin
            @(posedge clk);
            for (int i = 0; i < AUDIO_NCHAN; i++) begin
                if (reload_o[i]) reload_cnt[i]++;
            end
            if (ack_i) begin
                ack_i <= 1'b0;                              // ack lasts one cycle
            end else if (mem_req.req && !reset_i) begin
                if (!armed) begin
                    armed     = 1'b1;
                    lfsr      = lfsr_next(lfsr);
                    wait_left = lfsr[0];
                    lfsr      = lfsr_next(lfsr);
                    wait_left = wait_left * 2 + lfsr[0];    // 0..3 cycles
                end
                if (wait_left == 0) begin
                    armed  = 1'b0;
                    ack_i  <= 1'b1;
                    word_i <= fill_word;
                    c = mem_req.addr[15:8];
                    check_value($sformatf("chan%0d mem_req.addr", c), exp_addr[c], mem_req.addr);
                    if (exp_addr[c] == cfg[c].start + cfg[c].len)
                        exp_addr[c] = cfg[c].start;         // buffer wrap
                    else
                        exp_addr[c] = exp_addr[c] + 1'b1;
                    ack_cnt[c]++;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    task automatic load_cfg(input int t);
        for (int c = 0; c < AUDIO_NCHAN; c++) begin
            cfg[c].vol_l  <= vol_t'(field(t, 4 + c*5));
            cfg[c].vol_r  <= vol_t'(field(t, 5 + c*5));
            cfg[c].period <= PERIOD_W'(field(t, 6 + c*5));
            cfg[c].start  <= addr_t'(field(t, 7 + c*5));
            cfg[c].len    <= LENGTH_W'(field(t, 8 + c*5));
        end
        fill_word <= word_t'(field(t, 1));
    endtask

    // buffers refilled after cfg change, then mixer rounds flush
    task automatic settle(input bit en);
        int  base [AUDIO_NCHAN];
        int  cycles;
        bit  busy;
        base   = reload_cnt;
        cycles = 0;
        busy   = 1'b1;
        while (busy && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            busy = 1'b0;
            for (int c = 0; c < AUDIO_NCHAN; c++) begin
                if (en && reload_cnt[c] < base[c] + 2) busy = 1'b1;
            end
            if (!en && mem_req.req) busy = 1'b1;
        end
        if (busy) begin
            timed_out = 1'b1;
            $display("timeout: channels never settled (enable %0d)", en);
            return;
        end
        repeat (3 * (AUDIO_NCHAN + 2)) @(negedge clk);
    endtask

    // restart channel 2 while channel 0 holds the memory port
    task automatic restart_check(input int t);
        int cycles;
        int base_r;
        int base_a;
        cycles = 0;
        while (!(mem_req.req && mem_req.addr[15:8] == 0) && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles >= TIMEOUT) begin
            timed_out = 1'b1;
            $display("timeout: no channel 0 request seen before restart");
            return;
        end
        base_r = reload_cnt[2];
        base_a = ack_cnt[2];
        @(posedge clk);
        restart_i   <= 4'b0100;
        exp_addr[2] = addr_t'(field(t, 17));                // next fetch at start
        @(posedge clk);
        restart_i <= '0;
        cycles = 0;
        while (!(reload_cnt[2] > base_r && ack_cnt[2] > base_a) && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles >= TIMEOUT) begin
            timed_out = 1'b1;
            $display("timeout: restart gave no reload or no refetch on channel 2");
        end
    endtask

    task automatic run_test(input int t);
        int ones_l;
        int ones_r;
        int req_seen;
        bit en;
        en = 1'(field(t, 0));
        @(posedge clk);
        enable_i <= en;
        load_cfg(t);
        settle(en);
        if (timed_out) return;
        ones_l   = 0;
        ones_r   = 0;
        req_seen = 0;
        repeat (256) begin
            @(negedge clk);
            ones_l   += pdm_l;
            ones_r   += pdm_r;
            req_seen += mem_req.req;
        end
        check_value("pdm_l_o ones", field(t, 2), ones_l);
        check_value("pdm_r_o ones", field(t, 3), ones_r);
        if (!en) check_value("mem_req.req cycles", 0, req_seen);
        else restart_check(t);
        $display("test %0d enable %0d: %0d/%0d ones, errors so far %0d",
                 t, en, ones_l, ones_r, errors);
    endtask

    initial begin : main_flow
        errors    = 0;
        checks    = 0;
        timed_out = 1'b0;
        lfsr      = 16'd13;
        reset_i   = 1'b1;
        enable_i  = 1'b0;
        restart_i = '0;
        ack_i     = 1'b0;
        word_i    = '0;
        $readmemh("sim/audio_mixer_stim.txt", stim);
        for (int c = 0; c < AUDIO_NCHAN; c++) begin
            reload_cnt[c] = 0;
            ack_cnt[c]    = 0;
            exp_addr[c]   = addr_t'(field(0, 7 + c*5));
        end
        load_cfg(0);
        repeat (2) @(posedge clk);
        reset_i <= 1'b0;
        @(negedge clk);
        check_value("mem_req.req", 0, mem_req.req);
        check_value("reload_o", 0, reload_o);
        check_value("pdm_l_o", 0, pdm_l);
        check_value("pdm_r_o", 0, pdm_r);
        repeat (4) @(posedge clk);                          // idle arms start addresses
        for (int t = 0; t < NTESTS && !timed_out; t++) begin
            run_test(t);
        end
        errors += UUT.u_assert.fail_cnt;
        $display("tests %0d, checks %0d, errors %0d", NTESTS, checks, errors);
        if (timed_out || errors != 0) begin
            $display("Test failed");
        end else begin
            $display("Test passed");
        end
        $finish;
    end

endmodule

// File: src/audio_channel.sv
/* One playback channel: period timer, word buffer, address pointer and length count.
   Plays whatever the buffer holds when a sample is due; a late fetch repeats old data.
   Restart or enable low latch the start address at once; the reload pulse follows. */

module audio_channel
    import audio_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  logic      enable_i,
    input  chan_cfg_t cfg_i,
    input  logic      restart_i,
    input  logic      load_i,
    input  word_t     load_word_i,
    output logic      buf_ok_o,
    output addr_t     addr_o,
    output sample_t   sample_o,
    output logic      reload_o
);

    logic [PERIOD_W:0] period_cnt;      // msb set on underflow
    logic [LENGTH_W:0] len_cnt;         // msb set on underflow
    logic [LENGTH_W:0] len_next;
    word_t             buf_word;        // fetched sample pair
    logic              second;          // low byte due next
    logic              take;            // sample due this cycle
    logic              force_reload;

    assign take         = period_cnt[PERIOD_W];
    assign len_next     = len_cnt - 1'b1;
    assign force_reload = restart_i || !enable_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            period_cnt <= '0;
            len_cnt    <= '0;
            addr_o     <= '0;
            buf_word   <= '0;
            buf_ok_o   <= 1'b0;
            second     <= 1'b0;
            sample_o   <= '0;
            reload_o   <= 1'b0;
        end else begin
            reload_o   <= 1'b0;
            period_cnt <= period_cnt - 1'b1;

            if (load_i) begin
                buf_word <= load_word_i;
                buf_ok_o <= 1'b1;
            end

            if (take) begin
                second     <= !second;
                period_cnt <= {1'b0, cfg_i.period};         // sample lasts period+2
                sample_o   <= second ? buf_word[7:0] : buf_word[15:8];
                if (second) begin
                    buf_ok_o <= 1'b0;                       // word used up, refetch
                    if (len_cnt[LENGTH_W] || len_next[LENGTH_W]) begin
                        addr_o   <= cfg_i.start;            // wrap to buffer start
                        len_cnt  <= {1'b0, cfg_i.len};
                        reload_o <= 1'b1;
                    end else begin
                        addr_o  <= addr_o + 1'b1;
                        len_cnt <= len_next;
                    end
                end
            end

            // arm a reload on the next take
            if (force_reload) begin
                addr_o               <= cfg_i.start;        // next fetch goes to start
                len_cnt[LENGTH_W]    <= 1'b1;
                period_cnt[PERIOD_W] <= 1'b1;
                buf_ok_o             <= 1'b0;
                second               <= 1'b1;
            end
            if (!enable_i) begin
                reload_o <= 1'b0;                           // held quiet while idle
            end
        end
    end

endmodule

// File: src/audio_fetch.sv
/* Round-robin word fetch for the channel buffers over a req/ack port.
   An outstanding request is held until acked, so a slow memory stalls all channels. */

module audio_fetch
    import audio_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   enable_i,
    input  logic [AUDIO_NCHAN-1:0] buf_ok_i,
    input  addr_t                  chan_addr_i [AUDIO_NCHAN],
    output mem_req_t               mem_req_o,
    input  logic                   ack_i,
    input  word_t                  word_i,
    output logic [AUDIO_NCHAN-1:0] load_o,
    output word_t                  load_word_o
);

    logic [CHAN_W-1:0] fetch_chan;      // channel in current slot
    logic [CHAN_W-1:0] next_chan;
    fetch_phase_e      fetch_phase;
    logic              slot_done;       // no request, or request acked

    assign next_chan = (fetch_chan == CHAN_W'(AUDIO_NCHAN - 1)) ? '0 : fetch_chan + 1'b1;
    assign slot_done = !mem_req_o.req || ack_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mem_req_o.req <= 1'b0;
            load_o        <= '0;
            fetch_chan    <= '0;
            fetch_phase   <= FETCH_ISSUE;
        end else begin
            load_o <= '0;                                   // load is a single pulse

            case (fetch_phase)
                FETCH_ISSUE: begin
                    // only empty buffers get a fetch
                    mem_req_o.req  <= enable_i && !buf_ok_i[fetch_chan];
                    mem_req_o.addr <= chan_addr_i[fetch_chan];
                    fetch_phase    <= FETCH_WAIT;
                end

                FETCH_WAIT: begin
                    if (slot_done) begin
                        mem_req_o.req <= 1'b0;              // drops the edge after ack
                        if (mem_req_o.req) begin
                            load_o[fetch_chan] <= 1'b1;     // word to channel next cycle
                            load_word_o        <= word_i;
                        end
                        fetch_chan  <= next_chan;
                        fetch_phase <= FETCH_ISSUE;
                    end
                end

                default: begin
                    fetch_phase <= FETCH_ISSUE;
                end
            endcase
        end
    end

endmodule

// File: src/audio_mix.sv
/* Sequential left/right volume mix, one channel per cycle, AUDIO_NCHAN+2 cycles a round.
   The 16-bit accumulator wraps if the true sum of products leaves its range. */

module audio_mix
    import audio_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  logic      enable_i,
    input  chan_cfg_t cfg_i [AUDIO_NCHAN],
    input  sample_t   sample_i [AUDIO_NCHAN],
    output dac_t      dac_l_o,
    output dac_t      dac_r_o
);

    logic [MIX_CNT_W-1:0]    mix_chan;  // 0..N-1 latch, N drain, N+1 output
    logic [CHAN_W-1:0]       chan_sel;
    logic                    mac_vld;   // latched operands valid
    sample_t                 mix_val;
    vol_t                    vol_l_q;
    vol_t                    vol_r_q;
    logic signed [ACC_W-1:0] acc_l;
    logic signed [ACC_W-1:0] acc_r;

    // scale, saturate to 8 bits signed, then offset binary for the dac
    function automatic dac_t clamp_dac(input logic signed [ACC_W-1:0] acc);
        logic signed [ACC_W-1:0] scaled;
        scaled = acc >>> ACC_SHIFT;
        if (scaled < -128)
            return '0;
        else if (scaled > 127)
            return '1;
        else
            return {~scaled[DAC_W-1], scaled[DAC_W-2:0]};
    endfunction

    assign chan_sel = mix_chan[CHAN_W-1:0];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mix_chan <= '0;
            mac_vld  <= 1'b0;
            acc_l    <= '0;
            acc_r    <= '0;
            dac_l_o  <= '0;
            dac_r_o  <= '0;
        end else begin
            mac_vld <= (mix_chan < AUDIO_NCHAN);

            if (mix_chan < AUDIO_NCHAN) begin
                mix_val  <= sample_i[chan_sel];
                vol_l_q  <= cfg_i[chan_sel].vol_l;
                vol_r_q  <= cfg_i[chan_sel].vol_r;
                mix_chan <= mix_chan + 1'b1;
            end else if (mix_chan == AUDIO_NCHAN) begin
                mix_chan <= mix_chan + 1'b1;                // last product drains
            end else begin
                mix_chan <= '0;
                dac_l_o  <= clamp_dac(acc_l);               // once per round
                dac_r_o  <= clamp_dac(acc_r);
            end

            if (mix_chan == AUDIO_NCHAN + 1 || !enable_i) begin
                acc_l <= '0;                                // idle gives 128 at dac
                acc_r <= '0;
            end else if (mac_vld) begin
                acc_l <= acc_l + mix_val * $signed({1'b0, vol_l_q});
                acc_r <= acc_r + mix_val * $signed({1'b0, vol_r_q});
            end
        end
    end

endmodule

// File: src/audio_mixer.sv
/* Sample-playback mixer top: fetch scheduler, channel engines, mixer and two PDM outputs.
   Memory must hold req-to-ack ordering; ack without req is ignored. */

module audio_mixer
    import audio_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   enable_i,
    input  chan_cfg_t              cfg_i [AUDIO_NCHAN],
    input  logic [AUDIO_NCHAN-1:0] restart_i,
    output logic [AUDIO_NCHAN-1:0] reload_o,
    output mem_req_t               mem_req_o,
    input  logic                   ack_i,
    input  word_t                  word_i,
    output logic                   pdm_l_o,
    output logic                   pdm_r_o
);

    logic [AUDIO_NCHAN-1:0] buf_ok;     // channel buffer full
    logic [AUDIO_NCHAN-1:0] load;       // word delivery strobes
    addr_t                  chan_addr [AUDIO_NCHAN];
    word_t                  load_word;
    sample_t                chan_sample [AUDIO_NCHAN];
    dac_t                   dac_l;
    dac_t                   dac_r;

    audio_fetch u_fetch (
        .clk         (clk),
        .reset_i     (reset_i),
        .enable_i    (enable_i),
        .buf_ok_i    (buf_ok),
        .chan_addr_i (chan_addr),
        .mem_req_o   (mem_req_o),
        .ack_i       (ack_i),
        .word_i      (word_i),
        .load_o      (load),
        .load_word_o (load_word)
    );

    for (genvar i = 0; i < AUDIO_NCHAN; i++) begin : g_chan
        audio_channel u_chan (
            .clk         (clk),
            .reset_i     (reset_i),
            .enable_i    (enable_i),
            .cfg_i       (cfg_i[i]),
            .restart_i   (restart_i[i]),
            .load_i      (load[i]),
            .load_word_i (load_word),       // shared, strobe selects
            .buf_ok_o    (buf_ok[i]),
            .addr_o      (chan_addr[i]),
            .sample_o    (chan_sample[i]),
            .reload_o    (reload_o[i])
        );
    end

    audio_mix u_mix (
        .clk      (clk),
        .reset_i  (reset_i),
        .enable_i (enable_i),
        .cfg_i    (cfg_i),
        .sample_i (chan_sample),
        .dac_l_o  (dac_l),
        .dac_r_o  (dac_r)
    );

    audio_pdm_dac u_dac_l (
        .clk     (clk),
        .reset_i (reset_i),
        .value_i (dac_l),
        .pulse_o (pdm_l_o)
    );

    audio_pdm_dac u_dac_r (
        .clk     (clk),
        .reset_i (reset_i),
        .value_i (dac_r),
        .pulse_o (pdm_r_o)
    );

endmodule

// File: src/audio_pdm_dac.sv
/* First-order pulse-density modulator. Value v gives exactly v ones in any 256 cycles. */

module audio_pdm_dac
    import audio_pkg::*;
(
    input  logic clk,
    input  logic reset_i,
    input  dac_t value_i,
    output logic pulse_o
);

    dac_t         phase;                // running error
    logic [DAC_W:0] sum;                // carry in msb

    assign sum = {1'b0, phase} + {1'b0, value_i};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            phase   <= '0;
            pulse_o <= 1'b0;
        end else begin
            phase   <= sum[DAC_W-1:0];
            pulse_o <= sum[DAC_W];      // carry out is the pulse
        end
    end

endmodule

// File: src/audio_pkg.sv
/* Shared widths and types for the four-channel sample mixer.
   Channel count is set here only; CHAN_W assumes at least two channels. */

package audio_pkg;

    localparam int AUDIO_NCHAN = 4;                         // playback channels
    localparam int CHAN_W      = $clog2(AUDIO_NCHAN);       // channel index bits
    localparam int MIX_CNT_W   = $clog2(AUDIO_NCHAN + 2);   // mixer round counter bits
    localparam int VOL_W       = 7;                         // unsigned volume
    localparam int PERIOD_W    = 15;                        // sample period reload
    localparam int LENGTH_W    = 15;                        // words minus one
    localparam int ADDR_W      = 16;                        // memory word address
    localparam int DAC_W       = 8;                         // unsigned dac value
    localparam int ACC_SHIFT   = 6;                         // mix sum scale
    localparam int ACC_W       = 16;                        // mix accumulator

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [15:0]        word_t;     // two samples, high byte first
    typedef logic signed [7:0]  sample_t;
    typedef logic [VOL_W-1:0]   vol_t;
    typedef logic [DAC_W-1:0]   dac_t;

    // per-channel settings from the host side
    typedef struct packed {
        vol_t                vol_l;     // left volume
        vol_t                vol_r;     // right volume
        logic [PERIOD_W-1:0] period;    // cycles per sample minus two
        addr_t               start;     // first word of buffer
        logic [LENGTH_W-1:0] len;       // buffer words minus one
    } chan_cfg_t;

    // memory read request, held until ack
    typedef struct packed {
        logic  req;
        addr_t addr;
    } mem_req_t;

    // fetch scheduler phases
    typedef enum logic {
        FETCH_ISSUE,                    // decide on request for current channel
        FETCH_WAIT                      // wait for ack, then next channel
    } fetch_phase_e;

endpackage
